//--- vec_pkg.sv
/*
  Vector side constants and types for the store unit
  Lane count and queue depth must be powers of two
  One 64-bit operand word per lane and handshake
*/
package vec_pkg;

  // Lanes and instruction queue
  localparam int unsigned NrLanes       = 2;
  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned QueuePntWidth = $clog2(QueueDepth);
  localparam int unsigned QueueCntWidth = QueuePntWidth + 1;

  // Instruction ids and running mask
  localparam int unsigned IdWidth = 3;
  localparam int unsigned NrIds   = 1 << IdWidth;

  // Vector length limits
  localparam int unsigned MaxVl   = 32;
  localparam int unsigned VlWidth = 6;

  // Operand word per lane, and the full word over all lanes
  localparam int unsigned ElemWidthBits   = 64;
  localparam int unsigned WordBytes       = NrLanes * ElemWidthBits / 8;
  localparam int unsigned WordPntWidth    = $clog2(WordBytes);
  // Enough for MaxVl elements of 8 bytes
  localparam int unsigned TotalBytesWidth = VlWidth + 3;

  typedef logic [IdWidth-1:0]         id_t;
  typedef logic [VlWidth-1:0]         vl_t;
  typedef logic [TotalBytesWidth-1:0] bytes_t;
  typedef logic [WordPntWidth-1:0]    word_pnt_t;

  // Element width, an element takes 2**vew bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Target functional unit of a request
  typedef enum logic [1:0] {
    VFU_NONE  = 2'd0,
    VFU_ALU   = 2'd1,
    VFU_LOAD  = 2'd2,
    VFU_STORE = 2'd3
  } vfu_e;

endpackage

//--- mem_pkg.sv
/*
  Memory side constants and types for the simplified write channel
  Bursts are incremental with full 8-byte beats
*/
package mem_pkg;

  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned BeatBytes   = 8;
  localparam int unsigned BeatWidth   = BeatBytes * 8;
  localparam int unsigned BeatOffWidth = $clog2(BeatBytes);
  localparam int unsigned StrbWidth   = BeatBytes;
  // Holds the number of beats minus one
  localparam int unsigned LenWidth    = 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [BeatWidth-1:0] beat_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [LenWidth-1:0]  len_t;

endpackage

//--- vinsn_queue.sv
/*
  Store instruction queue with accept, issue and commit pointers
  Only VFU_STORE requests whose id is not running are taken
  A write response with an empty queue is ignored
  Responses retire instructions strictly in acceptance order
*/
`timescale 1ns/100ps

module vinsn_queue (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  vec_pkg::vfu_e               req_vfu_i,
  input  vec_pkg::id_t                req_id_i,
  input  vec_pkg::vl_t                req_vl_i,
  input  vec_pkg::vew_e               req_vsew_i,
  input  mem_pkg::addr_t              req_addr_i,
  input  logic [vec_pkg::NrIds-1:0]   req_running_i,
  output logic                        issue_valid_o,
  output vec_pkg::vl_t                issue_vl_o,
  output vec_pkg::vew_e               issue_vsew_o,
  output mem_pkg::addr_t              issue_addr_o,
  input  logic                        issue_done_i,
  input  logic                        b_valid_i,
  output logic                        done_valid_o,
  output vec_pkg::id_t                done_id_o,
  output logic                        store_pending_o
);

  // Entry payload
  vec_pkg::vl_t   vl_q   [vec_pkg::QueueDepth];
  vec_pkg::vew_e  vsew_q [vec_pkg::QueueDepth];
  mem_pkg::addr_t addr_q [vec_pkg::QueueDepth];
  vec_pkg::id_t   id_q   [vec_pkg::QueueDepth];

  // Pointers wrap on their own since the depth is a power of two
  logic [vec_pkg::QueuePntWidth-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  logic [vec_pkg::QueueCntWidth-1:0] issue_cnt_q, commit_cnt_q;

  logic [vec_pkg::NrIds-1:0] running_q, running_d;
  logic full, accept, retire;

  // Commit count covers every entry still in the queue
  assign full            = (commit_cnt_q == vec_pkg::QueueDepth);
  assign req_ready_o     = !full;
  assign store_pending_o = (commit_cnt_q != '0);

  // Stale ids stay pending on the port
  assign accept = req_valid_i && !full && (req_vfu_i == vec_pkg::VFU_STORE) &&
                  !running_q[req_id_i];
  assign retire = b_valid_i && store_pending_o;

  // Issue head
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_vl_o    = vl_q[issue_pnt_q];
  assign issue_vsew_o  = vsew_q[issue_pnt_q];
  assign issue_addr_o  = addr_q[issue_pnt_q];

  // The sequencer drops ids that are no longer running
  always_comb begin
    running_d = running_q & req_running_i;
    if (accept) begin
      running_d[req_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vl_q[accept_pnt_q]   <= req_vl_i;
      vsew_q[accept_pnt_q] <= req_vsew_i;
      addr_q[accept_pnt_q] <= req_addr_i;
      id_q[accept_pnt_q]   <= req_id_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      running_q    <= '0;
      done_valid_o <= 1'b0;
      done_id_o    <= '0;
    end else begin
      running_q    <= running_d;
      done_valid_o <= retire;
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      // Retired id is reported one cycle after the response
      if (retire) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
        done_id_o    <= id_q[commit_pnt_q];
      end
      if (accept && !issue_done_i) begin
        issue_cnt_q <= issue_cnt_q + 1'b1;
      end else if (!accept && issue_done_i) begin
        issue_cnt_q <= issue_cnt_q - 1'b1;
      end
      if (accept && !retire) begin
        commit_cnt_q <= commit_cnt_q + 1'b1;
      end else if (!accept && retire) begin
        commit_cnt_q <= commit_cnt_q - 1'b1;
      end
    end
  end

endmodule

//--- store_addrgen.sv
/*
  One write address request per issue-head store
  Base address must be aligned to the 8-byte beat, vl must be nonzero
  Bursts are not split at 4 KiB boundaries
*/
`timescale 1ns/100ps

module store_addrgen (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           issue_valid_i,
  input  vec_pkg::vl_t   issue_vl_i,
  input  vec_pkg::vew_e  issue_vsew_i,
  input  mem_pkg::addr_t issue_addr_i,
  input  logic           issue_done_i,
  output logic           aw_valid_o,
  input  logic           aw_ready_i,
  output mem_pkg::addr_t aw_addr_o,
  output mem_pkg::len_t  aw_len_o,
  output logic           burst_valid_o,
  output mem_pkg::len_t  burst_len_o
);

  vec_pkg::bytes_t total_bytes;
  mem_pkg::len_t   nr_beats;
  logic            aw_sent_q;

  // Bytes of the store, rounded up to whole beats
  assign total_bytes = vec_pkg::bytes_t'(issue_vl_i) << issue_vsew_i;
  assign nr_beats    = mem_pkg::len_t'(total_bytes >> mem_pkg::BeatOffWidth) +
                       mem_pkg::len_t'(|total_bytes[mem_pkg::BeatOffWidth-1:0]);

  // Burst stays open from the AW handshake to the last W beat
  assign burst_valid_o = aw_sent_q;
  assign burst_len_o   = aw_len_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_valid_o <= 1'b0;
      aw_sent_q  <= 1'b0;
    end else begin
      if (aw_valid_o && aw_ready_i) begin
        aw_valid_o <= 1'b0;
        aw_sent_q  <= 1'b1;
      end else if (issue_valid_i && !aw_valid_o && !aw_sent_q) begin
        aw_valid_o <= 1'b1;
      end
      // Closes the burst and frees the generator for the next head
      if (issue_done_i) begin
        aw_sent_q <= 1'b0;
      end
    end
  end

  // Payload captured when the request rises, then held until the next one
  always_ff @(posedge clk_i) begin
    if (issue_valid_i && !aw_valid_o && !aw_sent_q) begin
      aw_addr_o <= issue_addr_i;
      aw_len_o  <= nr_beats - 1'b1;
    end
  end

endmodule

//--- store_beat_packer.sv
/*
  Packs lane operand words into sequential write beats
  Undoes the element interleaving across lanes for every element width
  Each 16-byte lane word is two beats, the base is beat aligned
  Operands are acknowledged for all lanes at once
*/
`timescale 1ns/100ps

module store_beat_packer (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  input  vec_pkg::vl_t                                             issue_vl_i,
  input  vec_pkg::vew_e                                            issue_vsew_i,
  input  logic                                                     burst_valid_i,
  input  mem_pkg::len_t                                            burst_len_i,
  input  logic [vec_pkg::NrLanes-1:0][vec_pkg::ElemWidthBits-1:0]  operand_i,
  input  logic [vec_pkg::NrLanes-1:0]                              operand_valid_i,
  output logic                                                     operand_ready_o,
  output logic                                                     w_valid_o,
  input  logic                                                     w_ready_i,
  output mem_pkg::beat_t                                           w_data_o,
  output mem_pkg::strb_t                                           w_strb_o,
  output logic                                                     w_last_o,
  output logic                                                     issue_done_o
);

  // Byte pointer into the lane word, beat counter and bytes still to send
  vec_pkg::word_pnt_t byte_pnt_q;
  mem_pkg::len_t      beat_cnt_q;
  vec_pkg::bytes_t    bytes_left_q;
  vec_pkg::bytes_t    total_bytes;
  logic               beat_fire;
  logic               word_end;

  assign total_bytes = vec_pkg::bytes_t'(issue_vl_i) << issue_vsew_i;

  // Beat is complete once every lane has its word and the burst is open
  assign w_valid_o = burst_valid_i && (&operand_valid_i);
  assign beat_fire = w_valid_o && w_ready_i;
  assign w_last_o  = (beat_cnt_q == burst_len_i);
  assign word_end  = (byte_pnt_q == vec_pkg::word_pnt_t'(vec_pkg::WordBytes -
                                                          mem_pkg::BeatBytes));

  // Lanes move on when their word is used up or the store ends
  assign operand_ready_o = beat_fire && (word_end || w_last_o);
  assign issue_done_o    = beat_fire && w_last_o;

  // Byte shuffle
  // Sequential byte s is element s >> vsew, found in lane (elem % NrLanes)
  // at lane byte ((elem / NrLanes) << vsew) plus the byte inside the element
  always_comb begin : p_shuffle
    int unsigned seq_byte;
    int unsigned elem;
    int unsigned lane;
    int unsigned lane_byte;
    w_data_o = '0;
    w_strb_o = '0;
    for (int unsigned i = 0; i < mem_pkg::BeatBytes; i++) begin
      seq_byte  = byte_pnt_q + i;
      elem      = seq_byte >> issue_vsew_i;
      lane      = elem % vec_pkg::NrLanes;
      lane_byte = ((elem / vec_pkg::NrLanes) << issue_vsew_i) +
                  (seq_byte & ((1 << issue_vsew_i) - 1));
      // Partial last beat only strobes the bytes still owed
      if (i < bytes_left_q) begin
        w_strb_o[i]        = 1'b1;
        w_data_o[8*i +: 8] = operand_i[lane][8*lane_byte +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_pnt_q   <= '0;
      beat_cnt_q   <= '0;
      bytes_left_q <= '0;
    end else if (!burst_valid_i) begin
      // Idle, track the issue head so the counters are ready for its burst
      byte_pnt_q   <= '0;
      beat_cnt_q   <= '0;
      bytes_left_q <= total_bytes;
    end else if (beat_fire) begin
      beat_cnt_q   <= beat_cnt_q + 1'b1;
      bytes_left_q <= bytes_left_q - vec_pkg::bytes_t'(mem_pkg::BeatBytes);
      if (word_end) begin
        byte_pnt_q <= '0;
      end else begin
        byte_pnt_q <= byte_pnt_q + vec_pkg::word_pnt_t'(mem_pkg::BeatBytes);
      end
    end
  end

endmodule

//--- vstu_top.sv
/*
  Vector store unit top level
  Unit stride stores only, base aligned to the 8-byte beat
  Write response is a strobe with no error code and no back-pressure
*/
`timescale 1ns/100ps

module vstu_top (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  // Sequencer requests
  input  logic                                                     req_valid_i,
  output logic                                                     req_ready_o,
  input  vec_pkg::vfu_e                                            req_vfu_i,
  input  vec_pkg::id_t                                             req_id_i,
  input  vec_pkg::vl_t                                             req_vl_i,
  input  vec_pkg::vew_e                                            req_vsew_i,
  input  mem_pkg::addr_t                                           req_addr_i,
  input  logic [vec_pkg::NrIds-1:0]                                req_running_i,
  // Lane operands
  input  logic [vec_pkg::NrLanes-1:0][vec_pkg::ElemWidthBits-1:0]  operand_i,
  input  logic [vec_pkg::NrLanes-1:0]                              operand_valid_i,
  output logic                                                     operand_ready_o,
  // Write address
  output logic                                                     aw_valid_o,
  input  logic                                                     aw_ready_i,
  output mem_pkg::addr_t                                           aw_addr_o,
  output mem_pkg::len_t                                            aw_len_o,
  // Write data
  output logic                                                     w_valid_o,
  input  logic                                                     w_ready_i,
  output mem_pkg::beat_t                                           w_data_o,
  output mem_pkg::strb_t                                           w_strb_o,
  output logic                                                     w_last_o,
  // Write response and status
  input  logic                                                     b_valid_i,
  output logic                                                     done_valid_o,
  output vec_pkg::id_t                                             done_id_o,
  output logic                                                     store_pending_o
);

  logic           issue_valid;
  vec_pkg::vl_t   issue_vl;
  vec_pkg::vew_e  issue_vsew;
  mem_pkg::addr_t issue_addr;
  logic           issue_done;
  logic           burst_valid;
  mem_pkg::len_t  burst_len;

  vinsn_queue i_vinsn_queue (
    .clk_i,
    .rst_ni,
    .req_valid_i,
    .req_ready_o,
    .req_vfu_i,
    .req_id_i,
    .req_vl_i,
    .req_vsew_i,
    .req_addr_i,
    .req_running_i,
    .issue_valid_o   (issue_valid),
    .issue_vl_o      (issue_vl),
    .issue_vsew_o    (issue_vsew),
    .issue_addr_o    (issue_addr),
    .issue_done_i    (issue_done),
    .b_valid_i,
    .done_valid_o,
    .done_id_o,
    .store_pending_o
  );

  store_addrgen i_store_addrgen (
    .clk_i,
    .rst_ni,
    .issue_valid_i   (issue_valid),
    .issue_vl_i      (issue_vl),
    .issue_vsew_i    (issue_vsew),
    .issue_addr_i    (issue_addr),
    .issue_done_i    (issue_done),
    .aw_valid_o,
    .aw_ready_i,
    .aw_addr_o,
    .aw_len_o,
    .burst_valid_o   (burst_valid),
    .burst_len_o     (burst_len)
  );

  store_beat_packer i_store_beat_packer (
    .clk_i,
    .rst_ni,
    .issue_vl_i      (issue_vl),
    .issue_vsew_i    (issue_vsew),
    .burst_valid_i   (burst_valid),
    .burst_len_i     (burst_len),
    .operand_i,
    .operand_valid_i,
    .operand_ready_o,
    .w_valid_o,
    .w_ready_i,
    .w_data_o,
    .w_strb_o,
    .w_last_o,
    .issue_done_o    (issue_done)
  );

endmodule

//--- tb_vstu_asserts.sv
/*
  Handshake and status assertions, bound to the store unit top level
  Checked only while reset is released
*/
`timescale 1ns/100ps

module tb_vstu_asserts (
  input logic           clk_i,
  input logic           rst_ni,
  input logic           aw_valid_o,
  input logic           aw_ready_i,
  input mem_pkg::addr_t aw_addr_o,
  input mem_pkg::len_t  aw_len_o,
  input logic           w_valid_o,
  input logic           w_ready_i,
  input mem_pkg::beat_t w_data_o,
  input mem_pkg::strb_t w_strb_o,
  input logic           w_last_o,
  input logic           b_valid_i,
  input logic           done_valid_o,
  input logic           store_pending_o
);

  // Address request holds with its payload under back-pressure
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o) && $stable(aw_len_o))
    else $error("aw request changed while stalled");

  // Write beat holds under back-pressure
  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_strb_o) &&
                                $stable(w_last_o))
    else $error("w beat changed while stalled");

  // Done is the registered response
  done_after_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_i |=> done_valid_o)
    else $error("no done one cycle after the response");

  done_only_after_b: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_valid_o |-> $past(b_valid_i))
    else $error("done without a response one cycle before");

  pending_low_at_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !store_pending_o)
    else $error("store pending high after reset");

endmodule

bind vstu_top tb_vstu_asserts i_tb_vstu_asserts (.*);

//--- tb_vstu.sv
/*
  Testbench for the vector store unit
  Rows are applied in order, non-store rows are offered for four cycles
  Stalls and element data come from one LFSR
  Rows 7 to 11 fill the queue while write responses are held back
*/
`timescale 1ns/100ps

module tb_vstu;

  localparam int NumRows   = 12;
  localparam int HoldFirst = 7;
  localparam int HoldLast  = 11;

  logic clk_i;
  logic rst_ni;
  logic req_valid_i;
  logic req_ready_o;
  vec_pkg::vfu_e req_vfu_i;
  vec_pkg::id_t req_id_i;
  vec_pkg::vl_t req_vl_i;
  vec_pkg::vew_e req_vsew_i;
  mem_pkg::addr_t req_addr_i;
  logic [vec_pkg::NrIds-1:0] req_running_i;
  logic [vec_pkg::NrLanes-1:0][vec_pkg::ElemWidthBits-1:0] operand_i;
  logic [vec_pkg::NrLanes-1:0] operand_valid_i;
  logic operand_ready_o;
  logic aw_valid_o;
  logic aw_ready_i;
  mem_pkg::addr_t aw_addr_o;
  mem_pkg::len_t aw_len_o;
  logic w_valid_o;
  logic w_ready_i;
  mem_pkg::beat_t w_data_o;
  mem_pkg::strb_t w_strb_o;
  logic w_last_o;
  logic b_valid_i;
  logic done_valid_o;
  vec_pkg::id_t done_id_o;
  logic store_pending_o;

  // Stimulus table, one row per store request
  vec_pkg::vfu_e  row_vfu  [NumRows];
  vec_pkg::id_t   row_id   [NumRows];
  vec_pkg::vl_t   row_vl   [NumRows];
  vec_pkg::vew_e  row_vsew [NumRows];
  mem_pkg::addr_t row_addr [NumRows];
  logic           row_acc  [NumRows];
  logic [63:0]    elems    [NumRows][vec_pkg::MaxVl];

  // Rows in acceptance order
  int acc_q[$];
  int nr_accepted;
  int aw_idx, w_idx, w_beat, done_idx;
  int b_pending, b_delay, acc_cnt, b_cnt;
  int ln_store, ln_word;
  int cycle_cnt, cycle_limit;
  logic hold_b;
  logic [31:0] lfsr_q;

  vstu_top i_vstu_top (.*);

  always #20 clk_i = ~clk_i;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic rand_bit();
    lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    return lfsr_q[0];
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic int total_bytes(input int r);
    return int'(row_vl[r]) << int'(row_vsew[r]);
  endfunction

  function automatic int nr_beats(input int r);
    return (total_bytes(r) + 7) / 8;
  endfunction

  // A lane word covers 16 bytes over both lanes
  function automatic int nr_words(input int r);
    return (total_bytes(r) + 15) / 16;
  endfunction

  // Byte s of the store in memory order
  function automatic logic [7:0] elem_byte(input int r, input int s);
    int eb;
    eb = 1 << int'(row_vsew[r]);
    return elems[r][s / eb][8*(s % eb) +: 8];
  endfunction

  // Element k of a word goes to lane k%2 at byte (k/2)*eb
  function automatic logic [63:0] lane_word(input int r, input int w, input int l);
    logic [63:0] v;
    int eb, epw, e;
    v = '0;
    eb = 1 << int'(row_vsew[r]);
    epw = 16 / eb;
    for (int k = l; k < epw; k += 2) begin
      e = w * epw + k;
      if (e < int'(row_vl[r])) begin
        for (int b = 0; b < eb; b++) begin
          v[8*((k/2)*eb+b) +: 8] = elems[r][e][8*b +: 8];
        end
      end
    end
    return v;
  endfunction

  task automatic set_row(input int i, input vec_pkg::vfu_e vfu, input int id, input int vl,
                         input vec_pkg::vew_e vsew, input logic [31:0] addr, input logic acc);
    row_vfu[i]  = vfu;
    row_id[i]   = vec_pkg::id_t'(id);
    row_vl[i]   = vec_pkg::vl_t'(vl);
    row_vsew[i] = vsew;
    row_addr[i] = addr;
    row_acc[i]  = acc;
  endtask

  task automatic load_table();
    set_row(0,  vec_pkg::VFU_STORE, 0, 5,  vec_pkg::EW8,  32'h1000, 1'b1);
    set_row(1,  vec_pkg::VFU_STORE, 1, 17, vec_pkg::EW16, 32'h2008, 1'b1);
    set_row(2,  vec_pkg::VFU_ALU,   2, 4,  vec_pkg::EW32, 32'h3000, 1'b0);
    set_row(3,  vec_pkg::VFU_STORE, 3, 7,  vec_pkg::EW32, 32'h3010, 1'b1);
    set_row(4,  vec_pkg::VFU_STORE, 4, 9,  vec_pkg::EW64, 32'h4000, 1'b1);
    set_row(5,  vec_pkg::VFU_LOAD,  5, 8,  vec_pkg::EW8,  32'h5000, 1'b0);
    set_row(6,  vec_pkg::VFU_STORE, 6, 32, vec_pkg::EW8,  32'h6000, 1'b1);
    // Queue full group
    set_row(7,  vec_pkg::VFU_STORE, 7, 3,  vec_pkg::EW16, 32'h7000, 1'b1);
    set_row(8,  vec_pkg::VFU_STORE, 0, 31, vec_pkg::EW32, 32'h7100, 1'b1);
    set_row(9,  vec_pkg::VFU_STORE, 1, 1,  vec_pkg::EW64, 32'h7200, 1'b1);
    set_row(10, vec_pkg::VFU_STORE, 2, 32, vec_pkg::EW64, 32'h7400, 1'b1);
    set_row(11, vec_pkg::VFU_STORE, 3, 13, vec_pkg::EW8,  32'h7800, 1'b1);
  endtask

  // Stalls and lane model share the LFSR in one process
  always @(posedge clk_i) begin : stall_model
    int r;
    if (rst_ni) begin
      aw_ready_i <= rand_bit() | rand_bit();
      w_ready_i  <= rand_bit() | rand_bit();
      if (operand_ready_o) begin
        operand_valid_i <= '0;
        if (ln_word + 1 == nr_words(acc_q[ln_store])) begin
          ln_store++;
          ln_word = 0;
        end else begin
          ln_word++;
        end
      end else if (ln_store < acc_q.size()) begin
        r = acc_q[ln_store];
        for (int l = 0; l < vec_pkg::NrLanes; l++) begin
          // Data only changes while the lane is not valid
          if (!operand_valid_i[l] && (rand_bit() | rand_bit())) begin
            operand_valid_i[l] <= 1'b1;
            operand_i[l]       <= lane_word(r, ln_word, l);
          end
        end
      end
    end
  end

  // Address channel checks
  always @(posedge clk_i) begin : aw_monitor
    int r;
    if (rst_ni && aw_valid_o && aw_ready_i) begin
      assert (aw_idx < acc_q.size())
        else report_error("Address request arrived with no accepted store");
      r = acc_q[aw_idx];
      assert (aw_addr_o == row_addr[r])
        else report_error($sformatf("FAILED row%0d aw_addr expected %0h actual %0h",
                                    r, row_addr[r], aw_addr_o));
      assert (int'(aw_len_o) == nr_beats(r) - 1)
        else report_error($sformatf("FAILED row%0d aw_len expected %0h actual %0h",
                                    r, nr_beats(r) - 1, aw_len_o));
      aw_idx++;
    end
  end

  // Memory model, checks W beats and sends delayed responses
  always @(posedge clk_i) begin : mem_model
    int r, s;
    logic [63:0] exp_data, mask;
    logic [7:0] exp_strb;
    logic exp_last;
    if (rst_ni) begin
      b_valid_i <= 1'b0;
      if (w_valid_o && w_ready_i) begin
        assert (w_idx < acc_q.size())
          else report_error("Write beat arrived with no accepted store");
        r = acc_q[w_idx];
        exp_data = '0;
        exp_strb = '0;
        mask = '0;
        for (int i = 0; i < 8; i++) begin
          s = w_beat * 8 + i;
          if (s < total_bytes(r)) begin
            exp_strb[i] = 1'b1;
            exp_data[8*i +: 8] = elem_byte(r, s);
            mask[8*i +: 8] = 8'hff;
          end
        end
        exp_last = (w_beat == nr_beats(r) - 1);
        assert (w_strb_o == exp_strb)
          else report_error($sformatf("FAILED row%0d w_strb expected %0h actual %0h",
                                      r, exp_strb, w_strb_o));
        assert ((w_data_o & mask) == exp_data)
          else report_error($sformatf("FAILED row%0d w_data expected %0h actual %0h",
                                      r, exp_data, w_data_o & mask));
        assert (w_last_o == exp_last)
          else report_error($sformatf("FAILED row%0d w_last expected %0h actual %0h",
                                      r, exp_last, w_last_o));
        if (exp_last) begin
          w_idx++;
          w_beat = 0;
          b_pending++;
        end else begin
          w_beat++;
        end
      end
      if (b_pending > 0 && !hold_b && !b_valid_i) begin
        if (b_delay >= 3) begin
          b_valid_i <= 1'b1;
          b_pending--;
          b_delay = 0;
        end else begin
          b_delay++;
        end
      end
    end
  end

  // Pending flag and retire order
  always @(posedge clk_i) begin : status_monitor
    if (rst_ni) begin
      assert (store_pending_o == (acc_cnt != b_cnt))
        else report_error($sformatf("FAILED store_pending expected %0h actual %0h",
                                    acc_cnt != b_cnt, store_pending_o));
      if (req_valid_i && req_ready_o && req_vfu_i == vec_pkg::VFU_STORE) begin
        acc_cnt++;
      end
      if (b_valid_i) begin
        b_cnt++;
      end
      if (done_valid_o) begin
        assert (done_idx < acc_q.size())
          else report_error("Done pulse with no accepted store");
        assert (done_id_o == row_id[acc_q[done_idx]])
          else report_error($sformatf("FAILED done%0d done_id expected %0h actual %0h",
                                      done_idx, row_id[acc_q[done_idx]], done_id_o));
        done_idx++;
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      report_error("Timeout, the run did not finish within the cycle limit");
    end
  end

  initial begin
    clk_i = 1'b0;
    rst_ni <= 1'b0;
    req_valid_i <= 1'b0;
    req_vfu_i <= vec_pkg::VFU_NONE;
    req_id_i <= '0;
    req_vl_i <= '0;
    req_vsew_i <= vec_pkg::EW8;
    req_addr_i <= '0;
    req_running_i <= '0;
    operand_i <= '0;
    operand_valid_i <= '0;
    aw_ready_i <= 1'b0;
    w_ready_i <= 1'b0;
    b_valid_i <= 1'b0;
    hold_b = 1'b0;
    lfsr_q = 32'h32e7;
    load_table();
    cycle_limit = 10;
    nr_accepted = 0;
    for (int r = 0; r < NumRows; r++) begin
      cycle_limit += 4 * (nr_beats(r) + 10);
      if (row_acc[r]) begin
        nr_accepted++;
      end
      for (int k = 0; k < int'(row_vl[r]); k++) begin
        elems[r][k] = rand_bits(8 << int'(row_vsew[r]));
      end
    end

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    for (int r = 0; r < NumRows; r++) begin
      if (r == HoldFirst) begin
        // Start the full queue test from an empty queue
        req_valid_i <= 1'b0;
        while (store_pending_o) @(posedge clk_i);
        hold_b = 1'b1;
      end
      req_valid_i <= 1'b1;
      req_vfu_i   <= row_vfu[r];
      req_id_i    <= row_id[r];
      req_vl_i    <= row_vl[r];
      req_vsew_i  <= row_vsew[r];
      req_addr_i  <= row_addr[r];
      if (r == HoldLast) begin
        repeat (20) begin
          @(posedge clk_i);
          assert (!req_ready_o)
            else report_error($sformatf("FAILED row%0d req_ready expected %0h actual %0h",
                                        r, 1'b0, req_ready_o));
        end
        hold_b = 1'b0;
      end
      if (row_acc[r]) begin
        @(posedge clk_i);
        while (!req_ready_o) @(posedge clk_i);
        acc_q.push_back(r);
      end else begin
        repeat (4) @(posedge clk_i);
      end
    end
    req_valid_i <= 1'b0;

    while (done_idx < nr_accepted) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    assert (aw_idx == nr_accepted && w_idx == nr_accepted && done_idx == nr_accepted)
      else report_error("Request count does not match the accepted stores");
    assert (!store_pending_o)
      else report_error("Store pending still high after the last done");
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- verilog.f
vec_pkg.sv
mem_pkg.sv
vinsn_queue.sv
store_addrgen.sv
store_beat_packer.sv
vstu_top.sv
tb_vstu_asserts.sv
tb_vstu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vstu
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
